// File: source/gat_dims_pkg.sv
// sizes and latencies of the attention coefficient stage
// NUM_FEATURE_OUT must stay a power of two for the pairwise adder tree

package gat_dims_pkg;

  // ==========================================================================
  // row and weight geometry
  // ==========================================================================
  localparam int NUM_FEATURE_OUT = 8;
  localparam int A_LEN           = 2 * NUM_FEATURE_OUT;
  localparam int MAX_NODES       = 16;
  localparam int NUM_NODE_W      = $clog2(MAX_NODES + 1);

  localparam int WH_DEPTH        = 256;
  localparam int WH_ADDR_W       = $clog2(WH_DEPTH);

  localparam int FEAT_W          = 12;
  localparam int DATA_W          = 8;
  localparam int DMVM_W          = 24;
  // features, node count, source flag
  localparam int WH_ROW_W        = NUM_FEATURE_OUT * FEAT_W + NUM_NODE_W + 1;

  // ==========================================================================
  // pipeline and buffering
  // ==========================================================================
  localparam int COEF_SHIFT      = 8;
  // multiply stage plus log2 adder stages
  localparam int NUM_STAGES      = $clog2(NUM_FEATURE_OUT) + 1;
  // memory read register, tree, output register
  localparam int DMVM_LATENCY    = NUM_STAGES + 2;

  localparam int FIFO_DEPTH      = 32;
  localparam int FIFO_ADDR_W     = $clog2(FIFO_DEPTH);
  // leaves room for every row already in flight
  localparam int FIFO_AFULL      = FIFO_DEPTH - DMVM_LATENCY - 1;

endpackage

// File: source/gat_data_pkg.sv
// data types of the attention coefficient stage
// row layout is fixed: features from the top bits down, node count, flag in bit 0

package gat_data_pkg;

  // ==========================================================================
  // arithmetic types
  // ==========================================================================
  // one projected feature
  typedef logic signed [gat_dims_pkg::FEAT_W-1:0] feat_t;

  // one entry of the attention vector a
  typedef logic signed [gat_dims_pkg::DATA_W-1:0] weight_t;

  // partial or full dot product
  typedef logic signed [gat_dims_pkg::DMVM_W-1:0] dmvm_t;

  // scaled coefficient, never negative after relu
  typedef logic [gat_dims_pkg::DATA_W-1:0] coef_t;

  // ==========================================================================
  // addressing and rows
  // ==========================================================================
  typedef logic [gat_dims_pkg::WH_ADDR_W-1:0] wh_addr_t;

  typedef logic [gat_dims_pkg::NUM_NODE_W-1:0] num_node_t;

  typedef logic [gat_dims_pkg::WH_ROW_W-1:0] wh_row_t;

  // fetch controller states
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_SOURCE,
    ST_NEIGHBORS,
    ST_DRAIN
  } fetch_state_t;

endpackage

// File: source/wh_mem.sv
// single clock WH row store with one write and one read port
// read data appears the cycle after rd_en_i, contents undefined until written

`timescale 1ns/100ps

module wh_mem (
  input  logic                  clk,
  input  logic                  rst_n,

  // host write port
  input  logic                  we_i,
  input  gat_data_pkg::wh_addr_t waddr_i,
  input  gat_data_pkg::wh_row_t  wdata_i,

  // fetch read port
  input  logic                  rd_en_i,
  input  gat_data_pkg::wh_addr_t rd_addr_i,
  output gat_data_pkg::wh_row_t  rd_data_o,
  output logic                  rd_vld_o
);

  // ==========================================================================
  // storage
  // ==========================================================================
  gat_data_pkg::wh_row_t mem_q [gat_dims_pkg::WH_DEPTH];
  gat_data_pkg::wh_row_t rd_data_q;
  logic                  rd_vld_q;

  always_ff @(posedge clk) begin
    if (we_i) begin
      mem_q[waddr_i] <= wdata_i;
    end
  end

  // ==========================================================================
  // registered read
  // ==========================================================================
  // data register holds its last row when idle
  always_ff @(posedge clk) begin
    if (rd_en_i) begin
      rd_data_q <= mem_q[rd_addr_i];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_vld_q <= 1'b0;
    end else begin
      rd_vld_q <= rd_en_i;
    end
  end

  assign rd_data_o = rd_data_q;
  assign rd_vld_o  = rd_vld_q;

endmodule

// File: source/wh_fetch_ctrl.sv
// walks one subgraph, source row first, then the remaining N-1 rows in order
// source row must carry a node count from 1 to MAX_NODES; start ignored while busy

`timescale 1ns/100ps

module wh_fetch_ctrl (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start_i,
  input  gat_data_pkg::wh_addr_t base_addr_i,
  input  gat_data_pkg::wh_row_t  rd_data_i,
  input  logic                   rd_vld_i,
  input  logic                   afull_i,
  input  logic                   coef_vld_i,
  output logic                   rd_en_o,
  output gat_data_pkg::wh_addr_t rd_addr_o,
  output logic                   busy_o,
  output logic                   done_o
);

  gat_data_pkg::fetch_state_t state_q;
  gat_data_pkg::wh_addr_t     rd_addr_q;
  logic                       rd_en_q;
  gat_data_pkg::num_node_t    num_node_q;
  gat_data_pkg::num_node_t    rd_cnt_q;
  gat_data_pkg::num_node_t    push_cnt_q;
  gat_data_pkg::num_node_t    row_cnt;
  logic                       last_push;

  // node count field of the returning source row
  assign row_cnt   = rd_data_i[gat_dims_pkg::NUM_NODE_W:1];
  assign last_push = coef_vld_i && (push_cnt_q == num_node_q - 1'b1);

  // ==========================================================================
  // fetch state machine
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= gat_data_pkg::ST_IDLE;
      rd_en_q    <= 1'b0;
      rd_addr_q  <= '0;
      num_node_q <= '0;
      rd_cnt_q   <= '0;
      push_cnt_q <= '0;
    end else begin
      rd_en_q <= 1'b0;
      if (state_q != gat_data_pkg::ST_IDLE && coef_vld_i) begin
        push_cnt_q <= push_cnt_q + 1'b1;
      end
      case (state_q)
        gat_data_pkg::ST_IDLE: begin
          if (start_i) begin
            state_q    <= gat_data_pkg::ST_SOURCE;
            rd_en_q    <= 1'b1;
            rd_addr_q  <= base_addr_i;
            push_cnt_q <= '0;
          end
        end
        gat_data_pkg::ST_SOURCE: begin
          // wait for the source row to learn N
          if (rd_vld_i) begin
            num_node_q <= row_cnt;
            rd_cnt_q   <= 1'b1;
            if (row_cnt > 1) begin
              state_q <= gat_data_pkg::ST_NEIGHBORS;
              if (!afull_i) begin
                rd_en_q   <= 1'b1;
                rd_addr_q <= rd_addr_q + 1'b1;
                rd_cnt_q  <= 2'd2;
              end
            end else begin
              state_q <= gat_data_pkg::ST_DRAIN;
            end
          end
        end
        gat_data_pkg::ST_NEIGHBORS: begin
          if (rd_cnt_q == num_node_q) begin
            state_q <= gat_data_pkg::ST_DRAIN;
          end else if (!afull_i) begin
            rd_en_q   <= 1'b1;
            rd_addr_q <= rd_addr_q + 1'b1;
            rd_cnt_q  <= rd_cnt_q + 1'b1;
          end
        end
        default: begin
          // drain until the last coefficient lands
          if (last_push) begin
            state_q <= gat_data_pkg::ST_IDLE;
          end
        end
      endcase
    end
  end

  assign rd_en_o   = rd_en_q;
  assign rd_addr_o = rd_addr_q;
  assign busy_o    = (state_q != gat_data_pkg::ST_IDLE);
  assign done_o    = (state_q == gat_data_pkg::ST_DRAIN) && last_push;

endmodule

// File: source/dmvm.sv
// attention score pipeline, fixed latency of NUM_STAGES + 1 from wh_vld_i to coef_vld_o
// a_i should only change while no rows are in flight

`timescale 1ns/100ps

module dmvm (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  a_vld_i,
  input  logic [gat_dims_pkg::A_LEN*gat_dims_pkg::DATA_W-1:0] a_i,
  input  logic                  wh_vld_i,
  input  gat_data_pkg::wh_row_t wh_data_i,
  output logic                  coef_vld_o,
  output gat_data_pkg::coef_t   coef_o
);

  logic [gat_dims_pkg::A_LEN*gat_dims_pkg::DATA_W-1:0] a_q;

  // half 0 is a_src, half 1 is a_nbr
  gat_data_pkg::weight_t a_half [2][gat_dims_pkg::NUM_FEATURE_OUT];
  gat_data_pkg::feat_t   feat [gat_dims_pkg::NUM_FEATURE_OUT];

  // stage 0 holds products, later stages hold pairwise sums
  gat_data_pkg::dmvm_t tree_q [gat_dims_pkg::NUM_STAGES][2][gat_dims_pkg::NUM_FEATURE_OUT];
  logic [gat_dims_pkg::NUM_STAGES-1:0] vld_q;
  logic [gat_dims_pkg::NUM_STAGES-1:0] flg_q;

  gat_data_pkg::dmvm_t src_q;
  gat_data_pkg::dmvm_t src_sum;
  gat_data_pkg::dmvm_t score;
  gat_data_pkg::dmvm_t shifted;
  gat_data_pkg::coef_t coef_d;
  gat_data_pkg::coef_t coef_q;
  logic                coef_vld_q;

  // ==========================================================================
  // weight register and operand split
  // ==========================================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_q <= '0;
    end else if (a_vld_i) begin
      a_q <= a_i;
    end
  end

  always_comb begin
    for (int k = 0; k < gat_dims_pkg::NUM_FEATURE_OUT; k++) begin
      a_half[0][k] = a_q[k*gat_dims_pkg::DATA_W +: gat_dims_pkg::DATA_W];
      a_half[1][k] = a_q[(k+gat_dims_pkg::NUM_FEATURE_OUT)*gat_dims_pkg::DATA_W +:
                         gat_dims_pkg::DATA_W];
      // feature 0 sits in the top bits of the row
      feat[k] = wh_data_i[gat_dims_pkg::WH_ROW_W-1-k*gat_dims_pkg::FEAT_W -:
                          gat_dims_pkg::FEAT_W];
    end
  end

  // ==========================================================================
  // multiply and adder tree, both halves side by side
  // ==========================================================================
  always_ff @(posedge clk) begin
    for (int h = 0; h < 2; h++) begin
      for (int k = 0; k < gat_dims_pkg::NUM_FEATURE_OUT; k++) begin
        tree_q[0][h][k] <= a_half[h][k] * feat[k];
      end
      for (int s = 1; s < gat_dims_pkg::NUM_STAGES; s++) begin
        for (int k = 0; k < (gat_dims_pkg::NUM_FEATURE_OUT >> s); k++) begin
          tree_q[s][h][k] <= tree_q[s-1][h][2*k] + tree_q[s-1][h][2*k+1];
        end
      end
    end
  end

  // valid and source flag ride along with the tree
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      vld_q      <= '0;
      flg_q      <= '0;
      src_q      <= '0;
      coef_vld_q <= 1'b0;
    end else begin
      vld_q      <= {vld_q[gat_dims_pkg::NUM_STAGES-2:0], wh_vld_i};
      flg_q      <= {flg_q[gat_dims_pkg::NUM_STAGES-2:0], wh_vld_i & wh_data_i[0]};
      coef_vld_q <= vld_q[gat_dims_pkg::NUM_STAGES-1];
      if (flg_q[gat_dims_pkg::NUM_STAGES-1]) begin
        src_q <= tree_q[gat_dims_pkg::NUM_STAGES-1][0][0];
      end
    end
  end

  // ==========================================================================
  // score, relu, scaling
  // ==========================================================================
  // flagged row bypasses the source latch
  assign src_sum = flg_q[gat_dims_pkg::NUM_STAGES-1] ?
                   tree_q[gat_dims_pkg::NUM_STAGES-1][0][0] : src_q;
  assign score   = src_sum + tree_q[gat_dims_pkg::NUM_STAGES-1][1][0];
  assign shifted = score >>> gat_dims_pkg::COEF_SHIFT;

  always_comb begin
    if (score[gat_dims_pkg::DMVM_W-1]) begin
      coef_d = '0;
    end else if (|shifted[gat_dims_pkg::DMVM_W-1:gat_dims_pkg::DATA_W]) begin
      coef_d = '1;
    end else begin
      coef_d = shifted[gat_dims_pkg::DATA_W-1:0];
    end
  end

  always_ff @(posedge clk) begin
    coef_q <= coef_d;
  end

  assign coef_o     = coef_q;
  assign coef_vld_o = coef_vld_q;

endmodule

// File: source/coef_fifo.sv
// first word fall through FIFO for coefficients
// push on full and pop on empty are dropped

`timescale 1ns/100ps

module coef_fifo (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                push_i,
  input  gat_data_pkg::coef_t din_i,
  input  logic                pop_i,
  output gat_data_pkg::coef_t dout_o,
  output logic                empty_o,
  output logic                full_o,
  output logic                afull_o
);

  gat_data_pkg::coef_t mem_q [gat_dims_pkg::FIFO_DEPTH];
  logic [gat_dims_pkg::FIFO_ADDR_W-1:0] wr_ptr_q;
  logic [gat_dims_pkg::FIFO_ADDR_W-1:0] rd_ptr_q;
  logic [gat_dims_pkg::FIFO_ADDR_W:0]   count_q;
  logic                                 wr_en;
  logic                                 rd_en;

  // ==========================================================================
  // flags
  // ==========================================================================
  assign empty_o = (count_q == '0);
  assign full_o  = (count_q == gat_dims_pkg::FIFO_DEPTH);
  assign afull_o = (count_q >= gat_dims_pkg::FIFO_AFULL);

  assign wr_en = push_i && !full_o;
  assign rd_en = pop_i && !empty_o;

  // head entry is always visible
  assign dout_o = mem_q[rd_ptr_q];

  // ==========================================================================
  // storage and pointers
  // ==========================================================================
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem_q[wr_ptr_q] <= din_i;
    end
  end

  // pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (rd_en) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({wr_en, rd_en})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// File: source/gat_coef_top.sv
// attention coefficient stage: WH memory, fetch FSM, dmvm pipeline, output FIFO
// load a only while busy_o is low and the pipeline is empty

`timescale 1ns/100ps

module gat_coef_top (
  input  logic                   clk,
  input  logic                   rst_n,

  // host loading
  input  logic                   wh_we_i,
  input  gat_data_pkg::wh_addr_t wh_waddr_i,
  input  gat_data_pkg::wh_row_t  wh_wdata_i,
  input  logic                   a_vld_i,
  input  logic [gat_dims_pkg::A_LEN*gat_dims_pkg::DATA_W-1:0] a_i,

  // subgraph control
  input  logic                   start_i,
  input  gat_data_pkg::wh_addr_t base_addr_i,
  output logic                   busy_o,
  output logic                   done_o,

  // coefficient drain
  input  logic                   coef_rd_i,
  output gat_data_pkg::coef_t    coef_o,
  output logic                   coef_empty_o,
  output logic                   coef_full_o
);

  logic                   rd_en;
  gat_data_pkg::wh_addr_t rd_addr;
  gat_data_pkg::wh_row_t  rd_data;
  logic                   rd_vld;
  logic                   coef_vld;
  gat_data_pkg::coef_t    coef;
  logic                   afull;

  // ==========================================================================
  // datapath chain
  // ==========================================================================
  wh_mem u_wh_mem (
    .clk       (clk),
    .rst_n     (rst_n),
    .we_i      (wh_we_i),
    .waddr_i   (wh_waddr_i),
    .wdata_i   (wh_wdata_i),
    .rd_en_i   (rd_en),
    .rd_addr_i (rd_addr),
    .rd_data_o (rd_data),
    .rd_vld_o  (rd_vld)
  );

  wh_fetch_ctrl u_wh_fetch_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .start_i     (start_i),
    .base_addr_i (base_addr_i),
    .rd_data_i   (rd_data),
    .rd_vld_i    (rd_vld),
    .afull_i     (afull),
    .coef_vld_i  (coef_vld),
    .rd_en_o     (rd_en),
    .rd_addr_o   (rd_addr),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  dmvm u_dmvm (
    .clk        (clk),
    .rst_n      (rst_n),
    .a_vld_i    (a_vld_i),
    .a_i        (a_i),
    .wh_vld_i   (rd_vld),
    .wh_data_i  (rd_data),
    .coef_vld_o (coef_vld),
    .coef_o     (coef)
  );

  coef_fifo u_coef_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (coef_vld),
    .din_i   (coef),
    .pop_i   (coef_rd_i),
    .dout_o  (coef_o),
    .empty_o (coef_empty_o),
    .full_o  (coef_full_o),
    .afull_o (afull)
  );

endmodule

// File: bench/coef_model.svh
// reference model of the coefficient stage, included into the testbench module
// assumes only the first row of each subgraph carries the source flag

`ifndef COEF_MODEL_SVH
`define COEF_MODEL_SVH

// host side copies of the WH memory and the weight vector a
logic [gat_dims_pkg::WH_ROW_W-1:0] wh_img [gat_dims_pkg::WH_DEPTH];
int                                a_img  [gat_dims_pkg::A_LEN];

// signed feature k of a stored row, feature 0 in the top bits
function automatic int row_feature(input int addr, input int k);
  logic [gat_dims_pkg::FEAT_W-1:0] raw;
  raw = wh_img[addr % gat_dims_pkg::WH_DEPTH]
              [gat_dims_pkg::WH_ROW_W-1-k*gat_dims_pkg::FEAT_W -: gat_dims_pkg::FEAT_W];
  return $signed(raw);
endfunction

// a_src against the source row plus a_nbr against the current row
function automatic int expected_coef(input int src_addr, input int row_addr);
  int score;
  int limit;
  score = 0;
  limit = (1 << gat_dims_pkg::DATA_W) - 1;
  for (int k = 0; k < gat_dims_pkg::NUM_FEATURE_OUT; k++) begin
    score += a_img[k] * row_feature(src_addr, k);
    score += a_img[k + gat_dims_pkg::NUM_FEATURE_OUT] * row_feature(row_addr, k);
  end
  if (score < 0) begin
    return 0;
  end
  score = score >>> gat_dims_pkg::COEF_SHIFT;
  return (score > limit) ? limit : score;
endfunction

`endif

// File: bench/tb_gat_coef.sv
// random subgraph runs against the reference model, 12 subgraphs in total
// each 16 row block of WH holds one subgraph, block 0 has only large positive features

`timescale 1ns/100ps

module tb_gat_coef;

  localparam int NODES       = gat_dims_pkg::MAX_NODES;
  localparam int NUM_BLOCKS  = gat_dims_pkg::WH_DEPTH / NODES;
  localparam int NUM_RUNS    = 12;
  // memory load plus a slow reader margin for every subgraph
  localparam int CYCLE_LIMIT = gat_dims_pkg::WH_DEPTH +
                               NUM_RUNS * (NODES + gat_dims_pkg::DMVM_LATENCY + 4) * 8;

  logic                   clk = 1'b0;
  logic                   rst_n = 1'b0;
  logic                   wh_we_i = 1'b0;
  gat_data_pkg::wh_addr_t wh_waddr_i = '0;
  gat_data_pkg::wh_row_t  wh_wdata_i = '0;
  logic                   a_vld_i = 1'b0;
  logic [gat_dims_pkg::A_LEN*gat_dims_pkg::DATA_W-1:0] a_i = '0;
  logic                   start_i = 1'b0;
  gat_data_pkg::wh_addr_t base_addr_i = '0;
  logic                   busy_o;
  logic                   done_o;
  logic                   coef_rd_i = 1'b0;
  gat_data_pkg::coef_t    coef_o;
  logic                   coef_empty_o;
  logic                   coef_full_o;

  int exp_q[$];
  int start_cnt  = 0;
  int done_cnt   = 0;
  int cycle_cnt  = 0;
  bit rd_enable  = 1'b0;
  int rd_pct     = 100;

  `include "coef_model.svh"

  gat_coef_top uut (
    .clk          (clk),
    .rst_n        (rst_n),
    .wh_we_i      (wh_we_i),
    .wh_waddr_i   (wh_waddr_i),
    .wh_wdata_i   (wh_wdata_i),
    .a_vld_i      (a_vld_i),
    .a_i          (a_i),
    .start_i      (start_i),
    .base_addr_i  (base_addr_i),
    .busy_o       (busy_o),
    .done_o       (done_o),
    .coef_rd_i    (coef_rd_i),
    .coef_o       (coef_o),
    .coef_empty_o (coef_empty_o),
    .coef_full_o  (coef_full_o)
  );

  always #10 clk = ~clk;

  // ==========================================================================
  // failure reporting and checks
  // ==========================================================================
  task automatic report_failure(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input int expected, input logic [31:0] actual);
    assert (actual === expected) else begin
      report_failure($sformatf("mismatch at %0t ns: %s expected %0d, got %0d",
                               $time, name, expected, actual));
    end
  endtask

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      report_failure($sformatf("run hung: %0d cycles passed without finishing", CYCLE_LIMIT));
    end
  end

  // random reader, checks the head entry before popping it
  always @(negedge clk) begin
    coef_rd_i = 1'b0;
    if (rst_n && done_o) begin
      done_cnt++;
    end
    if (rst_n && rd_enable && !coef_empty_o && (($urandom % 100) < rd_pct)) begin
      assert (exp_q.size() > 0) else begin
        report_failure("the FIFO returned a coefficient that no subgraph should produce");
      end
      check_value("coef_o", exp_q.pop_front(), coef_o);
      coef_rd_i = 1'b1;
    end
  end

  // ==========================================================================
  // host tasks
  // ==========================================================================
  task automatic load_wh_memory();
    gat_data_pkg::wh_row_t row;
    for (int addr = 0; addr < gat_dims_pkg::WH_DEPTH; addr++) begin
      for (int k = 0; k < gat_dims_pkg::NUM_FEATURE_OUT; k++) begin
        if (addr < NODES) begin
          row[gat_dims_pkg::WH_ROW_W-1-k*gat_dims_pkg::FEAT_W -: gat_dims_pkg::FEAT_W] =
            1024 + $urandom % 1024;
        end else begin
          row[gat_dims_pkg::WH_ROW_W-1-k*gat_dims_pkg::FEAT_W -: gat_dims_pkg::FEAT_W] =
            $urandom;
        end
      end
      row[gat_dims_pkg::NUM_NODE_W:0] = '0;
      // first row of a block is its source, blocks 0 and 1 are full size
      if (addr % NODES == 0) begin
        row[gat_dims_pkg::NUM_NODE_W:1] = (addr < 2 * NODES) ? NODES : 1 + $urandom % NODES;
        row[0] = 1'b1;
      end
      wh_img[addr] = row;
      @(negedge clk);
      wh_we_i    = 1'b1;
      wh_waddr_i = addr;
      wh_wdata_i = row;
    end
    @(negedge clk);
    wh_we_i = 1'b0;
  endtask

  // mode 0 random, 1 all most negative, 2 all most positive
  task automatic load_weights(input int mode);
    for (int k = 0; k < gat_dims_pkg::A_LEN; k++) begin
      if (mode == 1) begin
        a_img[k] = -128;
      end else if (mode == 2) begin
        a_img[k] = 127;
      end else begin
        a_img[k] = int'($urandom % 256) - 128;
      end
      a_i[k*gat_dims_pkg::DATA_W +: gat_dims_pkg::DATA_W] = a_img[k][7:0];
    end
    @(negedge clk);
    a_vld_i = 1'b1;
    @(negedge clk);
    a_vld_i = 1'b0;
  endtask

  // reader stays off for the first hold cycles, one ignored start if asked
  task automatic run_subgraph(input int block, input int pct, input int hold, input bit extra);
    int base;
    int n;
    int k;
    base = block * NODES;
    n    = wh_img[base][gat_dims_pkg::NUM_NODE_W:1];
    for (int r = 0; r < n; r++) begin
      exp_q.push_back(expected_coef(base, base + r));
    end
    @(negedge clk);
    rd_enable   = (hold == 0);
    rd_pct      = pct;
    start_i     = 1'b1;
    base_addr_i = base;
    @(negedge clk);
    start_i = 1'b0;
    start_cnt++;
    k = 0;
    while (!done_o) begin
      check_value("busy_o", 1, busy_o);
      rd_enable   = (k >= hold);
      start_i     = extra && (k == 2);
      base_addr_i = ((block + 1) % NUM_BLOCKS) * NODES;
      k++;
      @(negedge clk);
    end
    start_i = 1'b0;
    check_value("busy_o", 1, busy_o);
    @(negedge clk);
    check_value("done_o", 0, done_o);
    check_value("busy_o", 0, busy_o);
  endtask

  // pop at full rate until about level entries remain, then hold the reader off
  task automatic drain_to_level(input int level);
    rd_enable = 1'b1;
    rd_pct    = 100;
    while (exp_q.size() > level) begin
      @(negedge clk);
    end
    rd_enable = 1'b0;
  endtask

  task automatic drain_fifo();
    rd_enable = 1'b1;
    rd_pct    = 100;
    while (exp_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (gat_dims_pkg::DMVM_LATENCY + 2) @(negedge clk);
    check_value("coef_empty_o", 1, coef_empty_o);
    check_value("done_o pulses", start_cnt, done_cnt);
  endtask

  // ==========================================================================
  // test sequence
  // ==========================================================================
  initial begin
    void'($urandom(32'h1e601941));
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("busy_o", 0, busy_o);
    check_value("done_o", 0, done_o);
    check_value("coef_empty_o", 1, coef_empty_o);
    check_value("coef_full_o", 0, coef_full_o);

    load_wh_memory();
    load_weights(0);
    for (int i = 0; i < 7; i++) begin
      // new weights for the last two random runs
      if (i == 5) begin
        load_weights(0);
      end
      run_subgraph($urandom % NUM_BLOCKS, 25 + $urandom % 76, 0, i == 2);
      drain_fifo();
    end

    // relu clamps to zero, then saturation at the top
    load_weights(1);
    run_subgraph(0, 100, 0, 1'b0);
    drain_fifo();
    load_weights(2);
    run_subgraph(0, 100, 0, 1'b0);
    drain_fifo();

    // two full subgraphs with the reader held off fill the FIFO to the top
    load_weights(0);
    run_subgraph(1, 100, 1000, 1'b0);
    run_subgraph(0, 100, 1000, 1'b0);
    check_value("coef_full_o", exp_q.size() >= gat_dims_pkg::FIFO_DEPTH, coef_full_o);

    // from a partly drained FIFO the next subgraph stalls the fetch on afull
    drain_to_level(20);
    run_subgraph(1, 60, 40, 1'b0);
    drain_fifo();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// File: files.f
+incdir+bench
source/gat_dims_pkg.sv
source/gat_data_pkg.sv
source/wh_mem.sv
source/wh_fetch_ctrl.sv
source/dmvm.sv
source/coef_fifo.sv
source/gat_coef_top.sv
bench/tb_gat_coef.sv

// File: Bender.yml
package:
  name: gat_coef_stage

sources:
  - source/gat_dims_pkg.sv
  - source/gat_data_pkg.sv
  - source/wh_mem.sv
  - source/wh_fetch_ctrl.sv
  - source/dmvm.sv
  - source/coef_fifo.sv
  - source/gat_coef_top.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_gat_coef.sv
